/* lsuPkg.sv */
// lsuPkg: shared opcode, request and state types plus decode helpers for the load/store unit
`default_nettype none

package lsuPkg;

  ////////////////////////////////////////
  // memory opcodes
  ////////////////////////////////////////

  // {store bit, funct3}; funct3[2] unsigned, funct3[1:0] size
  typedef enum logic [3:0] {
    lb  = 4'b0000,
    lh  = 4'b0001,
    lw  = 4'b0010,
    ld  = 4'b0011,
    lbu = 4'b0100,
    lhu = 4'b0101,
    lwu = 4'b0110,
    sb  = 4'b1000,
    sh  = 4'b1001,
    sw  = 4'b1010,
    sd  = 4'b1011
  } memOpT;

  // one access as handed in by the pipeline
  typedef struct packed {
    memOpT       op;
    logic [15:0] adr;        // byte address, word index on top
    logic [63:0] writeData;  // low Xlen bits used
    logic        fpAccess;   // fp load/store, enables NaN boxing
  } lsuReqT;

  typedef enum logic [1:0] {
    idle,
    waitMem,
    complete
  } lsuStateT;

  ////////////////////////////////////////
  // decode helpers
  ////////////////////////////////////////

  // 0 byte, 1 half, 2 word, 3 double
  function automatic logic [1:0] opSize(memOpT op);
    return op[1:0];
  endfunction

  function automatic logic opUnsigned(memOpT op);
    return op[2];  // zero-extend on load
  endfunction

  function automatic logic opIsStore(memOpT op);
    return op[3];
  endfunction

endpackage

`default_nettype wire

/* latencyTimer.sv */
// latencyTimer: down-counter that models the memory wait and flags when it runs out
`default_nettype none

module latencyTimer #(
  parameter int MemLatency = 3  // wait cycles, 1..15
) (
  input  logic clk,
  input  logic arstN,
  input  logic load,     // restart the wait
  output logic expired   // count hit zero after a load
);

  logic [3:0] count;
  logic       running;   // gates expired so it needs a load first

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      count   <= '0;
      running <= 1'b0;
    end else if (load) begin
      count   <= 4'(MemLatency);
      running <= 1'b1;
    end else if (running) begin
      if (count == 4'd0) begin
        running <= 1'b0;       // one expired cycle only
      end else begin
        count <= count - 4'd1;
      end
    end
  end

  assign expired = running && (count == 4'd0);

endmodule

`default_nettype wire

/* lsuFsm.sv */
// lsuFsm: sequences one access through idle, memory wait and complete, driving write and capture
`default_nettype none

module lsuFsm (
  input  logic              clk,
  input  logic              arstN,
  input  logic              start,
  input  logic              expired,      // from latencyTimer
  input  logic              isStore,      // registered request is a store
  output logic              busy,
  output logic              done,
  output logic              timerLoad,
  output logic              ramWrite,
  output logic              captureRead,
  output lsuPkg::lsuStateT  state
);

  import lsuPkg::*;

  lsuStateT nextState;

  ////////////////////////////////////////
  // state register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      idle:     if (start) nextState = waitMem;
      waitMem:  if (expired) nextState = complete;
      complete: nextState = idle;      // start here is dropped
      default:  nextState = idle;
    endcase
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  assign busy      = (state == waitMem);
  assign done      = (state == complete);
  assign timerLoad = (state == idle) && start;   // kick the wait off with the request

  // store data lands at the edge closing complete
  assign ramWrite = (state == complete) && isStore;

  // load result is taken on the step into complete
  // so it sits next to done for that one cycle
  assign captureRead = (state == waitMem) && expired && !isStore;

endmodule

`default_nettype wire

/* subwordWrite.sv */
// subwordWrite: replicates store data across byte lanes and builds the byte enables
`default_nettype none

module subwordWrite #(
  parameter int Xlen = 64
) (
  input  lsuPkg::lsuReqT     req,
  output logic [Xlen-1:0]    wordData,
  output logic [Xlen/8-1:0]  byteEn
);

  import lsuPkg::*;

  localparam int Lanes   = Xlen / 8;
  localparam int OffBits = $clog2(Lanes);

  // base masks, shifted to the aligned lane below
  localparam logic [Lanes-1:0] ByteMask = Lanes'(1);
  localparam logic [Lanes-1:0] HalfMask = Lanes'(2'b11);
  localparam logic [Lanes-1:0] WordMask = Lanes'(4'hf);

  logic [Xlen-1:0]    storeData;
  logic [OffBits-1:0] laneOff;
  logic [OffBits-1:0] halfOff;
  logic [OffBits-1:0] wordOff;

  assign storeData = req.writeData[Xlen-1:0];
  assign laneOff   = req.adr[OffBits-1:0];
  assign halfOff   = laneOff & ~OffBits'(1);  // align down to 2
  assign wordOff   = laneOff & ~OffBits'(3);  // align down to 4, zero at Xlen 32

  always_comb begin
    case (opSize(req.op))
      2'd0: begin                                  // sb
        wordData = {Lanes{storeData[7:0]}};
        byteEn   = ByteMask << laneOff;
      end
      2'd1: begin                                  // sh
        wordData = {(Xlen/16){storeData[15:0]}};
        byteEn   = HalfMask << halfOff;
      end
      2'd2: begin                                  // sw
        wordData = {(Xlen/32){storeData[31:0]}};
        byteEn   = WordMask << wordOff;
      end
      default: begin                               // sd, whole word at either Xlen
        wordData = storeData;
        byteEn   = '1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* subwordRead.sv */
// subwordRead picks the addressed byte, halfword or word and extends or NaN-boxes it
`default_nettype none

module subwordRead #(
  parameter int Xlen = 64
) (
  input  logic [Xlen-1:0]  readDataWord,
  input  logic [2:0]       adr,
  input  lsuPkg::memOpT    op,
  input  logic             fpAccess,
  output logic [Xlen-1:0]  readData
);

  import lsuPkg::*;

  logic [7:0]  byteSel;
  logic [15:0] halfSel;
  logic        isUns;
  logic        halfFill;   // upper fill bit for lh/flh

  assign isUns    = opUnsigned(op);
  assign halfFill = !isUns && (halfSel[15] || fpAccess);   // boxing only on signed ops

  if (Xlen == 64) begin : gRead64
    logic [31:0] wordSel;
    logic        wordFill;   // upper fill bit for lw/flw

    // byte and halfword lanes, indexed by the low address bits
    assign byteSel  = readDataWord[8*adr[2:0] +: 8];
    assign halfSel  = readDataWord[16*adr[2:1] +: 16];
    assign wordSel  = adr[2] ? readDataWord[63:32] : readDataWord[31:0];
    assign wordFill = !isUns && (wordSel[31] || fpAccess);

    ////////////////////////////////////////
    // extension mux
    ////////////////////////////////////////
    always_comb begin
      case (opSize(op))
        2'd0:    readData = {{(Xlen-8){byteSel[7] && !isUns}}, byteSel};   // lb/lbu
        2'd1:    readData = {{(Xlen-16){halfFill}}, halfSel};              // lh/lhu/flh
        2'd2:    readData = {{(Xlen-32){wordFill}}, wordSel};              // lw/lwu/flw
        default: readData = readDataWord;                                  // ld
      endcase
    end
  end else begin : gRead32
    assign byteSel  = readDataWord[8*adr[1:0] +: 8];
    assign halfSel  = adr[1] ? readDataWord[31:16] : readDataWord[15:0];

    always_comb begin
      case (opSize(op))
        2'd0:    readData = {{(Xlen-8){byteSel[7] && !isUns}}, byteSel};
        2'd1:    readData = {{(Xlen-16){halfFill}}, halfSel};
        default: readData = readDataWord;   // lw, lwu and ld all raw
      endcase
    end
  end

endmodule

`default_nettype wire

/* dataRam.sv */
// dataRam: word-wide synchronous data memory with per-byte write enables
`default_nettype none

module dataRam #(
  parameter int Xlen     = 64,
  parameter int MemWords = 64
) (
  input  logic                         clk,
  input  logic                         we,
  input  logic [Xlen/8-1:0]            byteEn,
  input  logic [$clog2(MemWords)-1:0]  wordAdr,
  input  logic [Xlen-1:0]              writeWord,
  output logic [Xlen-1:0]              readWord
);

  localparam int Lanes = Xlen / 8;

  logic [Xlen-1:0] mem [MemWords];

  ////////////////////////////////////////
  // byte-lane write
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < Lanes; i++) begin
        if (byteEn[i]) begin
          mem[wordAdr][8*i +: 8] <= writeWord[8*i +: 8];
        end
      end
    end
  end

  // registered read, every cycle
  // old data on a same-address write
  always_ff @(posedge clk) begin
    readWord <= mem[wordAdr];
  end

endmodule

`default_nettype wire

/* loadStoreUnit.sv */
// loadStoreUnit: memory-stage load/store unit, one access in flight over a slow data RAM
`default_nettype none

module loadStoreUnit #(
  parameter int Xlen       = 64,
  parameter int MemWords   = 64,
  parameter int MemLatency = 3
) (
  input  logic            clk,
  input  logic            arstN,
  input  logic            start,
  input  lsuPkg::lsuReqT  req,
  output logic            busy,
  output logic            done,
  output logic [Xlen-1:0] readData   // valid while done
);

  import lsuPkg::*;

  localparam int OffBits = $clog2(Xlen / 8);
  localparam int AdrBits = $clog2(MemWords);

  lsuReqT              reqQ;
  lsuStateT            fsmState;
  logic                timerLoad;
  logic                expired;
  logic                ramWrite;
  logic                captureRead;
  logic [Xlen-1:0]     wrWord;
  logic [Xlen/8-1:0]   wrByteEn;
  logic [Xlen-1:0]     ramWord;
  logic [Xlen-1:0]     loadData;

  ////////////////////////////////////////
  // request and result registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      reqQ     <= '0;
      readData <= '0;
    end else begin
      if (start && fsmState == idle) reqQ <= req;   // dropped while in flight
      if (captureRead) readData <= loadData;
    end
  end

  lsuFsm lsuFsm_i (
    .clk, .arstN, .start, .expired,
    .isStore    (opIsStore(reqQ.op)),
    .busy, .done, .timerLoad, .ramWrite, .captureRead,
    .state      (fsmState)
  );

  latencyTimer #(.MemLatency(MemLatency)) latencyTimer_i (
    .clk, .arstN, .load(timerLoad), .expired
  );

  subwordWrite #(.Xlen(Xlen)) subwordWrite_i (
    .req(reqQ), .wordData(wrWord), .byteEn(wrByteEn)
  );

  dataRam #(.Xlen(Xlen), .MemWords(MemWords)) dataRam_i (
    .clk, .we(ramWrite), .byteEn(wrByteEn),
    .wordAdr   (reqQ.adr[OffBits +: AdrBits]),   // word index above the lane bits
    .writeWord (wrWord),
    .readWord  (ramWord)
  );

  subwordRead #(.Xlen(Xlen)) subwordRead_i (
    .readDataWord(ramWord), .adr(reqQ.adr[2:0]), .op(reqQ.op),
    .fpAccess(reqQ.fpAccess), .readData(loadData)
  );

endmodule

`default_nettype wire

/* loadStoreUnit_checker.sv */
// loadStoreUnit_checker holds strobe protocol assertions bound into the access FSM
`default_nettype none

module loadStoreUnit_checker (
  input logic             clk,
  input logic             arstN,
  input logic             busy,
  input logic             done,
  input logic             expired,
  input lsuPkg::lsuStateT state
);

  import lsuPkg::*;

  ////////////////////////////////////////
  // strobe protocol
  ////////////////////////////////////////

  // done is a one-cycle pulse
  doneOnePulse: assert property (@(posedge clk) disable iff (!arstN)
    done |=> !done)
    else $error("done stayed high for more than one cycle");

  // every done closes a busy phase
  doneAfterBusy: assert property (@(posedge clk) disable iff (!arstN)
    $rose(done) |-> $past(busy))
    else $error("done rose without busy in the cycle before");

  expiredInWait: assert property (@(posedge clk) disable iff (!arstN)
    expired |-> state == waitMem)   // timer only runs out while the FSM waits on it
    else $error("memory wait expired outside the waitMem state");

endmodule

bind lsuFsm loadStoreUnit_checker lsuChecker_i (
  .clk, .arstN, .busy, .done, .expired, .state
);

`default_nettype wire

/* loadStoreUnit_tb.sv */
// loadStoreUnit_tb checks the load/store unit from a table of accesses plus a random phase
`default_nettype none

module loadStoreUnit_tb;

  import lsuPkg::*;

  localparam int Xlen       = 64;
  localparam int MemLatency = 3;
  localparam int ResetCycles = 16;
  localparam int RandOps    = 8;    // sd + lb + lhu each

  typedef struct packed {
    lsuReqT      req;
    logic [63:0] expData;
    logic        checkRd;   // loads only
    logic        intrude;   // second start while busy
  } rowT;

  logic            clk;
  logic            arstN;
  logic            start;
  lsuReqT          req;
  logic            busy;
  logic            done;
  logic [Xlen-1:0] readData;

  rowT         rows[$];
  logic [63:0] shadow [64];   // model of the words hit by the random phase
  int          seed = 7840;
  int          dataErrs;
  int          latErrs;
  int          flagErrs;
  int          cycles;
  int          cycleLimit = 1000;   // replaced once the table is known

  loadStoreUnit #(.Xlen(Xlen), .MemWords(64), .MemLatency(MemLatency)) loadStoreUnit_i (
    .clk, .arstN, .start, .req, .busy, .done, .readData
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////
  // timeout
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("timeout: no done seen within %0d cycles", cycleLimit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic checkData(input logic [Xlen-1:0] got, input logic [Xlen-1:0] exp,
                           input string what);
    if (got !== exp) begin
      dataErrs++;
      $display("Mismatch at %0t: %s readData %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flagErrs++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkLatency(input int got, input int exp, input string what);
    if (got != exp) begin
      latErrs++;
      $display("Mismatch at %0t: %s done after %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic addRow(input memOpT op, input logic [15:0] adr, input logic [63:0] wdata,
                        input logic fp, input logic [63:0] expData, input logic intrude);
    rowT r;
    r.req.op        = op;
    r.req.adr       = adr;
    r.req.writeData = wdata;
    r.req.fpAccess  = fp;
    r.expData       = expData;
    r.checkRd       = !op[3];   // store bit clear
    r.intrude       = intrude;
    rows.push_back(r);
  endtask

  // pulse start for one access, wait for done, check timing and result
  task automatic applyRow(input rowT r, input int idx);
    lsuReqT intruder;
    int     waited;
    intruder           = r.req;
    intruder.op        = sd;
    intruder.writeData = 64'hDEAD_BEEF_DEAD_BEEF;
    @(negedge clk);
    req    = r.req;
    start  = 1'b1;
    waited = 0;
    while (!done) begin
      @(negedge clk);
      waited++;
      if (!done) checkFlag(busy, 1'b1, $sformatf("busy in row %0d", idx));
      start = r.intrude && (waited == 2);   // lands in waitMem and must be dropped
      if (start) req = intruder;
    end
    start = 1'b0;
    checkFlag(busy, 1'b0, $sformatf("busy with done in row %0d", idx));
    checkLatency(waited, MemLatency + 2, $sformatf("row %0d", idx));
    if (r.checkRd) checkData(readData, r.expData[Xlen-1:0], $sformatf("row %0d", idx));
  endtask

  ////////////////////////////////////////
  // main flow
  ////////////////////////////////////////

  initial begin : mainFlow
    int         word;
    int         off;
    logic [63:0] data;
    logic [7:0]  b;
    logic [15:0] h;
    clk   = 1'b0;
    arstN = 1'b0;
    start = 1'b0;
    req   = '0;

    // word 1 built up by stores of each size
    addRow(sd,  16'd8,  64'h8877_6655_4433_2211, 1'b0, '0, 1'b0);
    addRow(sb,  16'd9,  64'hA5, 1'b0, '0, 1'b0);
    addRow(sh,  16'd12, 64'hBEEF, 1'b0, '0, 1'b0);
    addRow(sh,  16'd15, 64'h1234, 1'b0, '0, 1'b0);               // aligned down to 14
    addRow(ld,  16'd8,  '0, 1'b0, 64'h1234_BEEF_4433_A511, 1'b0);
    addRow(sd,  16'd16, 64'h0, 1'b0, '0, 1'b0);
    addRow(sw,  16'd21, 64'hCAFE_F00D, 1'b0, '0, 1'b0);          // upper half of word 2
    addRow(ld,  16'd16, '0, 1'b0, 64'hCAFE_F00D_0000_0000, 1'b0);
    // signed, unsigned and boxed extraction
    addRow(lb,  16'd9,  '0, 1'b0, 64'hFFFF_FFFF_FFFF_FFA5, 1'b0);
    addRow(lb,  16'd13, '0, 1'b0, 64'hFFFF_FFFF_FFFF_FFBE, 1'b0);
    addRow(lb,  16'd14, '0, 1'b0, 64'h34, 1'b0);
    addRow(lbu, 16'd9,  '0, 1'b0, 64'hA5, 1'b0);
    addRow(lh,  16'd9,  '0, 1'b0, 64'hFFFF_FFFF_FFFF_A511, 1'b0);
    addRow(lh,  16'd10, '0, 1'b0, 64'h4433, 1'b0);
    addRow(lh,  16'd13, '0, 1'b0, 64'hFFFF_FFFF_FFFF_BEEF, 1'b0);
    addRow(lhu, 16'd12, '0, 1'b0, 64'hBEEF, 1'b0);
    addRow(lw,  16'd12, '0, 1'b0, 64'h1234_BEEF, 1'b0);
    addRow(lw,  16'd22, '0, 1'b0, 64'hFFFF_FFFF_CAFE_F00D, 1'b0);
    addRow(lwu, 16'd20, '0, 1'b0, 64'hCAFE_F00D, 1'b0);
    addRow(lhu, 16'd22, '0, 1'b0, 64'hCAFE, 1'b0);
    addRow(lh,  16'd10, '0, 1'b1, 64'hFFFF_FFFF_FFFF_4433, 1'b0);   // flh
    addRow(lh,  16'd12, '0, 1'b1, 64'hFFFF_FFFF_FFFF_BEEF, 1'b0);   // flh
    addRow(lw,  16'd8,  '0, 1'b1, 64'hFFFF_FFFF_4433_A511, 1'b0);   // flw
    // store attempt while busy must not land
    addRow(ld,  16'd8,  '0, 1'b0, 64'h1234_BEEF_4433_A511, 1'b1);
    addRow(ld,  16'd8,  '0, 1'b0, 64'h1234_BEEF_4433_A511, 1'b0);

    // random words 8..39 through the shadow model
    for (int i = 0; i < RandOps; i++) begin
      word = 8 + ($random(seed) & 31);
      off  = $random(seed) & 7;
      data = {$random(seed), $random(seed)};
      shadow[word] = data;
      b = shadow[word][8*off +: 8];
      h = shadow[word][8*(off & 6) +: 16];
      addRow(sd,  16'(word * 8), data, 1'b0, '0, 1'b0);
      addRow(lb,  16'(word * 8 + off), '0, 1'b0, {{56{b[7]}}, b}, 1'b0);
      addRow(lhu, 16'(word * 8 + off), '0, 1'b0, {48'h0, h}, 1'b0);
    end
    cycleLimit = rows.size() * (MemLatency + 4) + ResetCycles + 20;

    repeat (ResetCycles) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);
    checkFlag(busy, 1'b0, "busy after reset");
    checkFlag(done, 1'b0, "done after reset");
    checkData(readData, '0, "readData after reset");

    foreach (rows[i]) applyRow(rows[i], i);

    $display("summary: %0d data errors, %0d latency errors, %0d flag errors",
             dataErrs, latErrs, flagErrs);
    if (dataErrs + latErrs + flagErrs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
lsuPkg.sv
latencyTimer.sv
lsuFsm.sv
subwordWrite.sv
subwordRead.sv
dataRam.sv
loadStoreUnit.sv
loadStoreUnit_checker.sv
loadStoreUnit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
set -e
set -o pipefail

verilator --binary --timing --assert --top-module loadStoreUnit_tb -f src.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "run.sh: simulation passed"
else
  echo "run.sh: simulation failed"
  exit 1
fi
